//--- pat_core.f
+incdir+src
src/pat_pkg.sv
src/pat_shifter.sv
src/pat_alu.sv
src/pat_data_mem.sv
src/pat_pc.sv
src/pat_decode.sv
src/pat_commit.sv
src/pat_core.sv
testbench/tb_pat_core.sv

//--- Makefile
TOP = tb_pat_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f pat_core.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- testbench/tb_pat_core.sv
`include "pat_params.svh"

module tb_pat_core;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	// instructions per section
	localparam int N_NOP = 20;
	localparam int N_ALU = 200;
	localparam int N_SHIFT = 4 * 8 * 2 * 2;  // op x amount x sign x (ldi, shift)
	localparam int N_MEM = 40 * 5;
	localparam int N_IO = 30 * 5;
	localparam int N_BRANCH = 40 * 3;
	localparam int N_DRAIN = 4;              // last commit lands two edges late
	localparam int N_TOTAL = N_NOP + N_ALU + N_SHIFT + N_MEM + N_IO + N_BRANCH + N_DRAIN;
	localparam int WATCHDOG_NS = N_TOTAL * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD;

	logic clk;
	logic reset;
	pat_pkg::instr_t instruction;
	pat_pkg::word_t inputs_level;
	pat_pkg::pc_t o_pc;
	pat_pkg::word_t o_acc;
	pat_pkg::word_t o_outputs;

	// reference model state
	pat_pkg::word_t m_acc;
	pat_pkg::word_t m_out;
	pat_pkg::pc_t m_pc;
	pat_pkg::word_t m_mem [`PAT_DMEM_DEPTH];
	pat_pkg::instr_t m_stage;   // instruction latched at the last edge
	logic model_live = 1'b0;    // no checks before the first edge

	integer seed = 36383;
	int acc_errors;
	int out_errors;
	int pc_errors;

	pat_core i_pat_core
	(
		.clk(clk),
		.reset(reset),
		.i_instruction(instruction),
		.i_inputs(inputs_level),
		.o_pc(o_pc),
		.o_acc(o_acc),
		.o_outputs(o_outputs)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ====================
	// instruction assembly
	// ====================
	function automatic pat_pkg::instr_t major_op(input pat_pkg::op_major_e op,
		input pat_pkg::word_t imm);
		return {op, imm};
	endfunction

	function automatic pat_pkg::instr_t minor_op(input pat_pkg::op_minor_e op,
		input logic [2:0] amount);
		return {`PAT_ESCAPE, op, 1'b0, amount};  // bit 3 unused
	endfunction

	function automatic pat_pkg::instr_t zero_op(input pat_pkg::op_zero_e op);
		return {`PAT_ESCAPE, `PAT_ESCAPE, op};
	endfunction

	function automatic pat_pkg::op_major_e mem_opcode(input int sel);
		case (sel)
			0: return pat_pkg::maj_ldm;
			1: return pat_pkg::maj_addm;
			2: return pat_pkg::maj_subm;
			3: return pat_pkg::maj_orm;
			default: return pat_pkg::maj_andm;
		endcase
	endfunction

	// shift rules written out bit by bit
	function automatic pat_pkg::word_t shift_ref(input logic [3:0] op,
		input pat_pkg::word_t a, input logic [2:0] n);
		pat_pkg::word_t low_ones;
		pat_pkg::word_t sign_fill;
		low_ones = (8'h01 << n) - 8'h01;         // n ones at the bottom
		sign_fill = a[7] ? ~(8'hFF >> n) : 8'h00; // n copies of the sign at the top
		case (op)
			pat_pkg::min_shl:  return a << n;
			pat_pkg::min_shlo: return (a << n) | low_ones;
			pat_pkg::min_shr:  return a >> n;
			default:           return (a >> n) | sign_fill;  // asr
		endcase
	endfunction

	// one instruction per cycle driven just after the edge
	task automatic present(input pat_pkg::instr_t instr);
		@(posedge clk);
		#1;
		instruction = instr;
	endtask

	// ====================
	// reference model
	// ====================
	always @(posedge clk)
	begin : model_step
		logic [3:0] major;
		logic [3:0] minor;
		pat_pkg::word_t imm;
		pat_pkg::pc_t next_pc;
		model_live = 1'b1;
		if (reset)
		begin
			m_acc = '0;
			m_out = '0;
			m_pc = '0;
			m_stage = zero_op(pat_pkg::zop_nop);
		end
		else
		begin
			major = m_stage[11:8];
			minor = m_stage[7:4];
			imm = m_stage[7:0];
			next_pc = m_pc + 10'd1;
			if (major != `PAT_ESCAPE)
			begin
				case (major)
					pat_pkg::maj_or:   m_acc = m_acc | imm;
					pat_pkg::maj_and:  m_acc = m_acc & imm;
					pat_pkg::maj_add:  m_acc = m_acc + imm;
					pat_pkg::maj_sub:  m_acc = m_acc - imm;
					pat_pkg::maj_ldi:  m_acc = imm;
					pat_pkg::maj_ldm:  m_acc = m_mem[imm[4:0]];  // low 5 bits address
					pat_pkg::maj_addm: m_acc = m_acc + m_mem[imm[4:0]];
					pat_pkg::maj_subm: m_acc = m_acc - m_mem[imm[4:0]];
					pat_pkg::maj_orm:  m_acc = m_acc | m_mem[imm[4:0]];
					pat_pkg::maj_andm: m_acc = m_acc & m_mem[imm[4:0]];
					pat_pkg::maj_stam: m_mem[imm[4:0]] = m_acc;
					pat_pkg::maj_bf:   next_pc = m_pc + pat_pkg::pc_t'(imm);
					pat_pkg::maj_bb:   next_pc = m_pc - pat_pkg::pc_t'(imm);
					default: ;
				endcase
			end
			else if (minor != `PAT_ESCAPE)
			begin
				case (minor)
					pat_pkg::min_shl, pat_pkg::min_shlo, pat_pkg::min_shr, pat_pkg::min_asr:
						m_acc = shift_ref(minor, m_acc, m_stage[2:0]);
					pat_pkg::min_in:  m_acc = inputs_level;  // level held in cycle k+1
					pat_pkg::min_out: m_out = m_acc;
					default: ;
				endcase
			end
			else if (m_stage[3:0] == pat_pkg::zop_not)
				m_acc = ~m_acc;
			m_pc = next_pc;
			m_stage = instruction;
		end
	end

	// ====================
	// checks at mid-cycle
	// ====================
	always @(negedge clk)
	begin
		if (model_live)
		begin
			acc_check: assert (o_acc === m_acc)
			else
			begin
				acc_errors++;
				$display("FAIL %0d ns: o_acc got %h expected %h", $time, o_acc, m_acc);
			end
			outputs_check: assert (o_outputs === m_out)
			else
			begin
				out_errors++;
				$display("FAIL %0d ns: o_outputs got %h expected %h", $time, o_outputs, m_out);
			end
			pc_check: assert (o_pc === m_pc)
			else
			begin
				pc_errors++;
				$display("FAIL %0d ns: o_pc got %h expected %h", $time, o_pc, m_pc);
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, stimulus never finished", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

	// ====================
	// stimulus
	// ====================
	initial
	begin : stimulus
		pat_pkg::word_t val;
		pat_pkg::dmem_addr_t addr;
		int sel;
		reset = 1'b1;
		instruction = zero_op(pat_pkg::zop_nop);
		inputs_level = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		// pc counts by one under nops
		repeat (N_NOP) present(zero_op(pat_pkg::zop_nop));

		// dependent alu ops back to back
		repeat (N_ALU)
		begin
			sel = $unsigned($random(seed)) % 6;
			val = pat_pkg::word_t'($random(seed));
			case (sel)
				0: present(major_op(pat_pkg::maj_ldi, val));
				1: present(major_op(pat_pkg::maj_add, val));
				2: present(major_op(pat_pkg::maj_sub, val));
				3: present(major_op(pat_pkg::maj_or, val));
				4: present(major_op(pat_pkg::maj_and, val));
				default: present(zero_op(pat_pkg::zop_not));
			endcase
		end

		// every shift and amount on a negative and a positive value
		for (int op = 0; op < 4; op++)
			for (int amt = 0; amt < 8; amt++)
				for (int neg = 0; neg < 2; neg++)
				begin
					val = pat_pkg::word_t'($random(seed));
					val[7] = (neg == 0);
					present(major_op(pat_pkg::maj_ldi, val));
					present(minor_op(pat_pkg::op_minor_e'(op), 3'(amt)));
				end

		// store then memory operand right behind it
		repeat (40)
		begin
			addr = pat_pkg::dmem_addr_t'($random(seed));
			present(major_op(pat_pkg::maj_ldi, pat_pkg::word_t'($random(seed))));
			present(major_op(pat_pkg::maj_stam, {3'($random(seed)), addr}));  // upper bits ignored
			sel = $unsigned($random(seed)) % 5;
			present(major_op(mem_opcode(sel), {3'($random(seed)), addr}));
			present(major_op(pat_pkg::maj_ldi, pat_pkg::word_t'($random(seed))));
			sel = $unsigned($random(seed)) % 5;
			present(major_op(mem_opcode(sel), {3'b000, addr}));
		end

		// in, then out of the modified acc, then out holds
		repeat (30)
		begin
			present(minor_op(pat_pkg::min_in, 3'd0));
			inputs_level = pat_pkg::word_t'($random(seed));  // held for the whole round
			present(zero_op(pat_pkg::zop_not));
			present(minor_op(pat_pkg::min_out, 3'd0));
			present(major_op(pat_pkg::maj_ldi, pat_pkg::word_t'($random(seed))));
			present(zero_op(pat_pkg::zop_nop));
		end

		// relative branches with sometimes two in a row
		repeat (40)
		begin
			sel = $unsigned($random(seed)) % 2;
			val = pat_pkg::word_t'($random(seed));
			if (sel != 0)
				present(major_op(pat_pkg::maj_bb, val));
			else
				present(major_op(pat_pkg::maj_bf, val));
			sel = $unsigned($random(seed)) % 3;
			val = pat_pkg::word_t'($random(seed));
			case (sel)
				0: present(major_op(pat_pkg::maj_bf, val));
				1: present(major_op(pat_pkg::maj_bb, val));
				default: present(zero_op(pat_pkg::zop_nop));
			endcase
			present(zero_op(pat_pkg::zop_nop));
		end

		repeat (N_DRAIN) present(zero_op(pat_pkg::zop_nop));
		@(negedge clk);
		#1;  // after the checks of this negedge
		$display("errors: %0d (o_acc %0d, o_outputs %0d, o_pc %0d)",
			acc_errors + out_errors + pc_errors, acc_errors, out_errors, pc_errors);
		if (acc_errors + out_errors + pc_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- src/pat_core.sv
module pat_core
(
	input logic clk,
	input logic reset,
	input pat_pkg::instr_t i_instruction,
	input pat_pkg::word_t i_inputs,
	output pat_pkg::pc_t o_pc,
	output pat_pkg::word_t o_acc,
	output pat_pkg::word_t o_outputs
);

	// memory side
	pat_pkg::dmem_addr_t rd_addr;
	pat_pkg::word_t rd_data;
	logic wr_en;
	pat_pkg::dmem_addr_t wr_addr;
	pat_pkg::word_t wr_data;

	// decode to stage 2
	pat_pkg::alu_op_e alu_op;
	pat_pkg::commit_e commit;
	pat_pkg::word_t operand;
	pat_pkg::dmem_addr_t store_addr;

	// decode to pc
	logic branch_fwd;
	logic branch_back;
	pat_pkg::word_t branch_offset;

	// ====================
	// stage 1
	// ====================
	pat_decode u_decode
	(
		.clk(clk),
		.reset(reset),
		.i_instruction(i_instruction),
		.i_rd_data(rd_data),
		.o_rd_addr(rd_addr),
		.o_alu_op(alu_op),
		.o_commit(commit),
		.o_operand(operand),
		.o_store_addr(store_addr),
		.o_branch_fwd(branch_fwd),
		.o_branch_back(branch_back),
		.o_branch_offset(branch_offset)
	);

	pat_data_mem u_data_mem
	(
		.clk(clk),
		.i_rd_addr(rd_addr),
		.i_wr_en(wr_en),
		.i_wr_addr(wr_addr),
		.i_wr_data(wr_data),
		.o_rd_data(rd_data)
	);

	pat_pc u_pc
	(
		.clk(clk),
		.reset(reset),
		.i_branch_fwd(branch_fwd),
		.i_branch_back(branch_back),
		.i_branch_offset(branch_offset),
		.o_pc(o_pc)
	);

	// ====================
	// stage 2
	// ====================
	pat_commit u_commit
	(
		.clk(clk),
		.reset(reset),
		.i_alu_op(alu_op),
		.i_commit(commit),
		.i_operand(operand),
		.i_store_addr(store_addr),
		.i_inputs(i_inputs),
		.o_acc(o_acc),
		.o_outputs(o_outputs),
		.o_wr_en(wr_en),
		.o_wr_addr(wr_addr),
		.o_wr_data(wr_data)
	);

endmodule

//--- src/pat_commit.sv
module pat_commit
(
	input logic clk,
	input logic reset,
	input pat_pkg::alu_op_e i_alu_op,
	input pat_pkg::commit_e i_commit,
	input pat_pkg::word_t i_operand,
	input pat_pkg::dmem_addr_t i_store_addr,
	input pat_pkg::word_t i_inputs,
	output pat_pkg::word_t o_acc,
	output pat_pkg::word_t o_outputs,
	output logic o_wr_en,
	output pat_pkg::dmem_addr_t o_wr_addr,
	output pat_pkg::word_t o_wr_data
);

	pat_pkg::word_t alu_y;

	// a is the live acc, so dependent ops back to back need no bypass
	pat_alu u_alu
	(
		.i_a(o_acc),
		.i_b(i_operand),
		.i_op(i_alu_op),
		.o_y(alu_y)
	);

	// ====================
	// commit
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_acc <= '0;
			o_outputs <= '0;
		end
		else
		begin
			case (i_commit)
				pat_pkg::commit_acc_alu: o_acc <= alu_y;
				pat_pkg::commit_acc_in:  o_acc <= i_inputs;   // level sampled in cycle k+1
				pat_pkg::commit_out:     o_outputs <= o_acc;  // acc before this edge
				default: ;
			endcase
		end
	end

	// strobe comes straight off the stage register in decode
	// so the store lands on the same edge as an acc update would
	assign o_wr_en = (i_commit == pat_pkg::commit_store);
	assign o_wr_addr = i_store_addr;
	assign o_wr_data = o_acc;

endmodule

//--- src/pat_decode.sv
`include "pat_params.svh"

module pat_decode
(
	input logic clk,
	input logic reset,
	input pat_pkg::instr_t i_instruction,
	input pat_pkg::word_t i_rd_data,
	output pat_pkg::dmem_addr_t o_rd_addr,
	output pat_pkg::alu_op_e o_alu_op,
	output pat_pkg::commit_e o_commit,
	output pat_pkg::word_t o_operand,
	output pat_pkg::dmem_addr_t o_store_addr,
	output logic o_branch_fwd,
	output logic o_branch_back,
	output pat_pkg::word_t o_branch_offset
);

	// instruction fields
	logic [3:0] major;
	logic [3:0] minor;
	logic [3:0] zop;
	pat_pkg::word_t imm8;
	logic [2:0] imm3;

	// decoded, ahead of the stage register
	pat_pkg::alu_op_e alu_op_d;
	pat_pkg::commit_e commit_d;
	pat_pkg::word_t imm_d;
	logic src_mem_d;
	logic fwd_d;
	logic back_d;

	// stage register
	pat_pkg::word_t imm_q;  // immediate, already widened
	logic src_mem_q;        // operand comes from data memory

	assign major = i_instruction[11:8];
	assign imm8 = i_instruction[7:0];
	assign minor = i_instruction[7:4];
	assign zop = i_instruction[3:0];
	assign imm3 = i_instruction[2:0];

	// ====================
	// three-level decode
	// ====================
	always_comb
	begin
		alu_op_d = pat_pkg::alu_pass_b;
		commit_d = pat_pkg::commit_none;  // unlisted opcodes fall out as nop
		imm_d = imm8;
		src_mem_d = 1'b0;
		fwd_d = 1'b0;
		back_d = 1'b0;
		if (major != `PAT_ESCAPE)
		begin
			case (major)
				pat_pkg::maj_or:   begin alu_op_d = pat_pkg::alu_or; commit_d = pat_pkg::commit_acc_alu; end
				pat_pkg::maj_and:  begin alu_op_d = pat_pkg::alu_and; commit_d = pat_pkg::commit_acc_alu; end
				pat_pkg::maj_add:  begin alu_op_d = pat_pkg::alu_add; commit_d = pat_pkg::commit_acc_alu; end
				pat_pkg::maj_sub:  begin alu_op_d = pat_pkg::alu_sub; commit_d = pat_pkg::commit_acc_alu; end
				pat_pkg::maj_ldi:  commit_d = pat_pkg::commit_acc_alu;  // pass b
				pat_pkg::maj_addm:
				begin
					alu_op_d = pat_pkg::alu_add;
					commit_d = pat_pkg::commit_acc_alu;
					src_mem_d = 1'b1;
				end
				pat_pkg::maj_subm:
				begin
					alu_op_d = pat_pkg::alu_sub;
					commit_d = pat_pkg::commit_acc_alu;
					src_mem_d = 1'b1;
				end
				pat_pkg::maj_orm:
				begin
					alu_op_d = pat_pkg::alu_or;
					commit_d = pat_pkg::commit_acc_alu;
					src_mem_d = 1'b1;
				end
				pat_pkg::maj_andm:
				begin
					alu_op_d = pat_pkg::alu_and;
					commit_d = pat_pkg::commit_acc_alu;
					src_mem_d = 1'b1;
				end
				pat_pkg::maj_ldm:  begin commit_d = pat_pkg::commit_acc_alu; src_mem_d = 1'b1; end
				pat_pkg::maj_stam: commit_d = pat_pkg::commit_store;
				pat_pkg::maj_bf:   fwd_d = 1'b1;   // pc only
				pat_pkg::maj_bb:   back_d = 1'b1;
				default: ;
			endcase
		end
		else if (minor != `PAT_ESCAPE)
		begin
			imm_d = {{(`PAT_DATA_W-3){1'b0}}, imm3};  // shift amount, zero-extended
			case (minor)
				pat_pkg::min_shl:  begin alu_op_d = pat_pkg::alu_shl; commit_d = pat_pkg::commit_acc_alu; end
				pat_pkg::min_shlo: begin alu_op_d = pat_pkg::alu_shlo; commit_d = pat_pkg::commit_acc_alu; end
				pat_pkg::min_shr:  begin alu_op_d = pat_pkg::alu_shr; commit_d = pat_pkg::commit_acc_alu; end
				pat_pkg::min_asr:  begin alu_op_d = pat_pkg::alu_asr; commit_d = pat_pkg::commit_acc_alu; end
				pat_pkg::min_in:   commit_d = pat_pkg::commit_acc_in;
				pat_pkg::min_out:  commit_d = pat_pkg::commit_out;
				default: ;
			endcase
		end
		else if (zop == pat_pkg::zop_not)
		begin
			alu_op_d = pat_pkg::alu_not;
			commit_d = pat_pkg::commit_acc_alu;
		end
	end

	// latched at edge k+1, stage 2 commits at k+2
	always_ff @(posedge clk)
	begin
		imm_q <= imm_d;
		if (reset)
		begin
			o_alu_op <= pat_pkg::alu_pass_b;
			o_commit <= pat_pkg::commit_none;
			src_mem_q <= 1'b0;
			o_branch_fwd <= 1'b0;
			o_branch_back <= 1'b0;
		end
		else
		begin
			o_alu_op <= alu_op_d;
			o_commit <= commit_d;
			src_mem_q <= src_mem_d;
			o_branch_fwd <= fwd_d;
			o_branch_back <= back_d;
		end
	end

	assign o_rd_addr = pat_pkg::dmem_addr_t'(imm_q);    // read during cycle k+1
	assign o_store_addr = pat_pkg::dmem_addr_t'(imm_q);
	assign o_operand = src_mem_q ? i_rd_data : imm_q;
	assign o_branch_offset = imm_q;

endmodule

//--- src/pat_pc.sv
module pat_pc
(
	input logic clk,
	input logic reset,
	input logic i_branch_fwd,
	input logic i_branch_back,
	input pat_pkg::word_t i_branch_offset,
	output pat_pkg::pc_t o_pc
);

	pat_pkg::pc_t offset;  // immediate is unsigned

	assign offset = pat_pkg::pc_t'(i_branch_offset);

	// all arithmetic wraps at the pc width
	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else if (i_branch_fwd)
			o_pc <= o_pc + offset;   // fwd wins
		else if (i_branch_back)
			o_pc <= o_pc - offset;
		else
			o_pc <= o_pc + 1'b1;
	end

endmodule

//--- src/pat_data_mem.sv
`include "pat_params.svh"

module pat_data_mem
#(
	parameter int DEPTH = `PAT_DMEM_DEPTH
)
(
	input logic clk,
	input pat_pkg::dmem_addr_t i_rd_addr,
	input logic i_wr_en,
	input pat_pkg::dmem_addr_t i_wr_addr,
	input pat_pkg::word_t i_wr_data,
	output pat_pkg::word_t o_rd_data
);

	pat_pkg::word_t mem [DEPTH];  // contents undefined until written

	// async read, a store on this edge is seen by the next cycle's load
	assign o_rd_data = mem[i_rd_addr];

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

endmodule

//--- src/pat_alu.sv
module pat_alu
(
	input pat_pkg::word_t i_a,
	input pat_pkg::word_t i_b,
	input pat_pkg::alu_op_e i_op,
	output pat_pkg::word_t o_y
);

	pat_pkg::word_t shift_y;

	// amount is the 3-bit minor immediate
	pat_shifter u_shifter
	(
		.i_a(i_a),
		.i_amount(i_b[2:0]),
		.i_op(i_op),
		.o_y(shift_y)
	);

	always_comb
	begin
		case (i_op)
			pat_pkg::alu_or:     o_y = i_a | i_b;
			pat_pkg::alu_and:    o_y = i_a & i_b;
			pat_pkg::alu_not:    o_y = ~i_a;      // b ignored
			pat_pkg::alu_add:    o_y = i_a + i_b;  // wraps, no carry out
			pat_pkg::alu_sub:    o_y = i_a - i_b;
			pat_pkg::alu_pass_b: o_y = i_b;       // ldi, ldm
			default:             o_y = shift_y;
		endcase
	end

endmodule

//--- src/pat_shifter.sv
module pat_shifter
(
	input pat_pkg::word_t i_a,
	input logic [2:0] i_amount,
	input pat_pkg::alu_op_e i_op,
	output pat_pkg::word_t o_y
);

	// ====================
	// shift select
	// ====================
	always_comb
	begin
		case (i_op)
			pat_pkg::alu_shlo:
				o_y = ~((~i_a) << i_amount);  // vacated low bits come in as ones
			pat_pkg::alu_shr:
				o_y = i_a >> i_amount;         // zero fill
			pat_pkg::alu_asr:
				o_y = $signed(i_a) >>> i_amount;  // sign bit replicated
			default:
				o_y = i_a << i_amount;         // shl
		endcase
	end

endmodule

//--- src/pat_pkg.sv
`include "pat_params.svh"

package pat_pkg;

	typedef logic [`PAT_DATA_W-1:0] word_t;
	typedef logic [`PAT_PC_W-1:0] pc_t;
	typedef logic [`PAT_INSTR_W-1:0] instr_t;
	typedef logic [`PAT_DMEM_AW-1:0] dmem_addr_t;

	// ====================
	// opcode spaces
	// ====================
	// major level, 8-bit immediate
	typedef enum logic [3:0]
	{
		maj_or = 4'd0, maj_and = 4'd1, maj_addm = 4'd2, maj_subm = 4'd3,
		maj_add = 4'd4, maj_sub = 4'd5, maj_ldi = 4'd6, maj_ldm = 4'd7,
		maj_bf = 4'd8, maj_bb = 4'd9, maj_stam = 4'd11,
		maj_orm = 4'd13, maj_andm = 4'd14,
		maj_escape = `PAT_ESCAPE
	} op_major_e;

	// minor level, bits 7..4, 3-bit immediate in bits 2..0
	typedef enum logic [3:0]
	{
		min_shl = 4'd0, min_shlo = 4'd1, min_shr = 4'd2, min_asr = 4'd3,
		min_in = 4'd5,
		min_out = 4'd8,
		min_escape = `PAT_ESCAPE
	} op_minor_e;

	// zero-operand level, bits 3..0
	typedef enum logic [3:0]
	{
		zop_not = 4'd0,
		zop_nop = 4'd15
	} op_zero_e;

	// ====================
	// stage-2 control
	// ====================
	typedef enum logic [3:0]
	{
		alu_or, alu_and, alu_not, alu_add, alu_sub,
		alu_shl, alu_shlo, alu_shr, alu_asr, alu_pass_b
	} alu_op_e;

	typedef enum logic [2:0]
	{
		commit_none, commit_acc_alu, commit_acc_in, commit_store, commit_out
	} commit_e;

endpackage

//--- src/pat_params.svh
`ifndef PAT_PARAMS_SVH
`define PAT_PARAMS_SVH

// ====================
// datapath widths
// ====================
`define PAT_DATA_W      8   // accumulator and data memory word
`define PAT_PC_W        10  // instruction address space
`define PAT_INSTR_W     12  // major opcode plus 8-bit immediate

// ====================
// data memory
// ====================
`define PAT_DMEM_DEPTH  32
`define PAT_DMEM_AW     5   // low immediate bits only

// all-ones opcode, drops decode into the next opcode level
`define PAT_ESCAPE      4'b1111

`endif
